// ==== hdl/mldsa_z_pkg.sv ====
package mldsa_z_pkg;

    // ----------------------------------------------------------
    // ML-DSA constants used by the z encoding path
    // ----------------------------------------------------------

    // Prime modulus q of the ML-DSA ring
    localparam int unsigned MLDSA_Q = 8380417;

    // A coefficient reduced modulo q fits in 23 bits
    localparam int unsigned COEF_W = 23;

    // gamma1 is a power of two and this is its exponent
    localparam int unsigned GAMMA1_LOG = 19;

    // The encoded value gamma1 - z spans [0, 2*gamma1) so it needs
    // one bit more than the exponent
    localparam int unsigned ZENC_W = GAMMA1_LOG + 1;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------

    // One coefficient of z, stored modulo q
    typedef logic [COEF_W-1:0] coef_t;

    // One encoded field as it appears in the signature byte string
    typedef logic [ZENC_W-1:0] zenc_t;

endpackage

// ==== hdl/z_coef_gather.sv ====
`timescale 1ns/1ps

module z_coef_gather #(
    parameter int unsigned NUM_LANES = 4
) (
    input  logic                                        clk,
    input  logic                                        reset_n,
    input  logic                                        zeroize_i,
    input  logic                                        coef_valid_i,
    input  mldsa_z_pkg::coef_t                          coef_i,
    output logic                                        lanes_valid_o,
    output mldsa_z_pkg::coef_t [NUM_LANES-1:0]          lanes_coef_o
);

    import mldsa_z_pkg::*;

    // Counter wide enough to address every lane
    localparam int unsigned CNT_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [CNT_W-1:0] lane_cnt;
    logic             last_lane;

    // High when the next accepted coefficient completes the group
    assign last_lane = (lane_cnt == CNT_W'(NUM_LANES - 1));

    // ----------------------------------------------------------
    // Lane counter and group strobe
    // ----------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_cnt      <= '0;
            lanes_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            // A partial group is dropped and the next one starts at lane 0
            lane_cnt      <= '0;
            lanes_valid_o <= 1'b0;
        end else begin
            // The strobe lasts a single cycle by default
            lanes_valid_o <= 1'b0;
            if (coef_valid_i) begin
                if (last_lane) begin
                    lane_cnt      <= '0;
                    lanes_valid_o <= 1'b1;
                end else begin
                    lane_cnt <= lane_cnt + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Lane registers
    // ----------------------------------------------------------

    // Each accepted coefficient lands in the lane the counter points at.
    // The group stays put until the first coefficient of the next group
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            lanes_coef_o <= '0;
        end else if (coef_valid_i) begin
            lanes_coef_o[lane_cnt] <= coef_t'(coef_i);
        end
    end

endmodule

// ==== hdl/sigencode_z_unit.sv ====
`timescale 1ns/1ps

module sigencode_z_unit (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               valid_i,
    input  mldsa_z_pkg::coef_t data_i,
    output logic               valid_o,
    output mldsa_z_pkg::zenc_t data_o
);

    import mldsa_z_pkg::*;

    // gamma1 as an operand of the first subtraction
    localparam coef_t GAMMA1 = coef_t'(1) << GAMMA1_LOG;

    // Only the low field bits of q matter for the final correction
    localparam zenc_t Q_LOW = zenc_t'(MLDSA_Q);

    // Stage 0 results before the pipeline register
    coef_t diff;
    logic  borrow;

    // Pipeline register contents
    zenc_t diff_q;
    logic  no_borrow_q;

    // ----------------------------------------------------------
    // Stage 0 computes gamma1 - z
    // ----------------------------------------------------------

    // The extra top bit catches the borrow when z is above gamma1,
    // which is the case for a negative z held as q + z
    assign {borrow, diff} = {1'b0, GAMMA1} - {1'b0, data_i};

    // Valid bit follows the data through the register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (zeroize_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Only the bits that reach the field are kept after the register
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            diff_q      <= '0;
            no_borrow_q <= 1'b0;
        end else if (valid_i) begin
            diff_q      <= diff[ZENC_W-1:0];
            no_borrow_q <= ~borrow;
        end
    end

    // ----------------------------------------------------------
    // Stage 1 applies the modular correction
    // ----------------------------------------------------------

    // With a borrow the difference wrapped modulo 2^k, so adding q gives
    // gamma1 - z + q whose low field bits are the encoding
    assign data_o = no_borrow_q ? diff_q : (diff_q + Q_LOW);

endmodule

// ==== hdl/z_beat_packer.sv ====
`timescale 1ns/1ps

module z_beat_packer #(
    parameter  int unsigned NUM_LANES = 4,
    localparam int unsigned BEAT_W    = NUM_LANES * mldsa_z_pkg::ZENC_W / 2
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize_i,
    input  logic                               valid_i,
    input  mldsa_z_pkg::zenc_t [NUM_LANES-1:0] enc_i,
    output logic                               word_valid_o,
    output logic [BEAT_W-1:0]                  word_o,
    output logic                               word_last_o
);

    import mldsa_z_pkg::*;

    // The packed field is split into two equal beats
    if (NUM_LANES % 2 != 0) begin : g_lanes_check
        $error("NUM_LANES must be even");
    end

    // State tells which beat is on the outputs
    typedef enum logic [1:0] {
        PACK_IDLE,
        PACK_LOW,
        PACK_HIGH
    } pack_state_e;

    pack_state_e           state_q;
    pack_state_e           state_d;
    logic [2*BEAT_W-1:0]   field;
    logic [BEAT_W-1:0]     hi_q;
    logic                  accept;

    // Lane 0 sits in the least significant bits
    assign field = enc_i;

    // A new group can be taken unless the low beat is still out,
    // so a group may follow straight after a high beat
    assign accept = valid_i && (state_q != PACK_LOW);

    // ----------------------------------------------------------
    // Beat sequencing
    // ----------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            PACK_IDLE: state_d = accept ? PACK_LOW : PACK_IDLE;
            PACK_LOW:  state_d = PACK_HIGH;
            PACK_HIGH: state_d = accept ? PACK_LOW : PACK_IDLE;
            default:   state_d = PACK_IDLE;
        endcase
    end

    // Framing outputs are registered copies of the next state
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q      <= PACK_IDLE;
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else if (zeroize_i) begin
            state_q      <= PACK_IDLE;
            word_valid_o <= 1'b0;
            word_last_o  <= 1'b0;
        end else begin
            state_q      <= state_d;
            word_valid_o <= (state_d != PACK_IDLE);
            word_last_o  <= (state_d == PACK_HIGH);
        end
    end

    // ----------------------------------------------------------
    // Beat data
    // ----------------------------------------------------------

    // Low half leaves at once and the high half waits one cycle in hi_q
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            word_o <= '0;
            hi_q   <= '0;
        end else if (accept) begin
            word_o <= field[BEAT_W-1:0];
            hi_q   <= field[2*BEAT_W-1:BEAT_W];
        end else if (state_q == PACK_LOW) begin
            word_o <= hi_q;
        end
    end

endmodule

// ==== hdl/sigencode_z_top.sv ====
`timescale 1ns/1ps

module sigencode_z_top #(
    parameter  int unsigned NUM_LANES = 4,
    localparam int unsigned BEAT_W    = NUM_LANES * mldsa_z_pkg::ZENC_W / 2
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               coef_valid_i,
    input  mldsa_z_pkg::coef_t coef_i,
    output logic               word_valid_o,
    output logic [BEAT_W-1:0]  word_o,
    output logic               word_last_o
);

    import mldsa_z_pkg::*;

    // Gathered group on its way to the encoders
    logic                      lanes_valid;
    coef_t [NUM_LANES-1:0]     lanes_coef;

    // Encoder results, all lanes move in lockstep
    logic  [NUM_LANES-1:0]     enc_valid;
    zenc_t [NUM_LANES-1:0]     enc_data;

    // ----------------------------------------------------------
    // Serial to parallel
    // ----------------------------------------------------------

    z_coef_gather #(
        .NUM_LANES (NUM_LANES)
    ) gather0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .coef_valid_i  (coef_valid_i),
        .coef_i        (coef_i),
        .lanes_valid_o (lanes_valid),
        .lanes_coef_o  (lanes_coef)
    );

    // One encoder per lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        sigencode_z_unit u_unit (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .valid_i   (lanes_valid),
            .data_i    (lanes_coef[i]),
            .valid_o   (enc_valid[i]),
            .data_o    (enc_data[i])
        );
    end

    // ----------------------------------------------------------
    // Two-beat output
    // ----------------------------------------------------------

    // Lane 0 valid stands for the whole group
    z_beat_packer #(
        .NUM_LANES (NUM_LANES)
    ) packer0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .valid_i      (enc_valid[0]),
        .enc_i        (enc_data),
        .word_valid_o (word_valid_o),
        .word_o       (word_o),
        .word_last_o  (word_last_o)
    );

endmodule

// ==== dv/sigencode_z_properties.sv ====
`timescale 1ns/1ps

module sigencode_z_properties (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic coef_valid_i,
    input logic lanes_valid_i,
    input logic word_valid_i,
    input logic word_last_i
);

    // Number of assertion failures, read by the testbench at the end
    int unsigned fail_count = 0;

    // ----------------------------------------------------------
    // Two-beat framing
    // ----------------------------------------------------------

    // A low beat is always followed by its high beat
    a_second_beat: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (word_valid_i && !word_last_i) |=> (word_valid_i && word_last_i)
    ) else begin
        fail_count++;
        $error("Low beat was not followed by the high beat");
    end

    // The valid window closes right after the high beat
    a_two_only: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (word_valid_i && word_last_i) |=> !word_valid_i
    ) else begin
        fail_count++;
        $error("Output valid lasted longer than two beats");
    end

    // word_last marks only the second of two valid cycles
    a_last_second: assert property (@(posedge clk) disable iff (!reset_n)
        word_last_i |-> (word_valid_i && $past(word_valid_i) && !$past(word_last_i))
    ) else begin
        fail_count++;
        $error("Last flag seen outside the second beat");
    end

    // Group strobe comes one cycle after the last coefficient,
    // so the first beat lands three cycles after that coefficient
    a_latency: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        ($past(lanes_valid_i, 2) && !$past(zeroize_i, 1) && !$past(zeroize_i, 2))
        |-> ($past(coef_valid_i, 3) && word_valid_i && !word_last_i)
    ) else begin
        fail_count++;
        $error("First beat did not arrive three cycles after the last coefficient");
    end

    // ----------------------------------------------------------
    // Reset and zeroize
    // ----------------------------------------------------------

    // Outputs are quiet during reset and right after zeroize
    a_clear: assert property (@(posedge clk)
        (!reset_n || $past(zeroize_i)) |-> (!word_valid_i && !word_last_i)
    ) else begin
        fail_count++;
        $error("Output strobes not cleared by reset or zeroize");
    end

    // No beat without a fresh complete group behind it
    a_fresh_group: assert property (@(posedge clk) disable iff (!reset_n)
        (word_valid_i && !word_last_i) |-> $past(lanes_valid_i, 2)
    ) else begin
        fail_count++;
        $error("Beat appeared without a complete group being gathered");
    end

endmodule

bind sigencode_z_top sigencode_z_properties props0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .zeroize_i     (zeroize_i),
    .coef_valid_i  (coef_valid_i),
    .lanes_valid_i (lanes_valid),
    .word_valid_i  (word_valid_o),
    .word_last_i   (word_last_o)
);

// ==== dv/sigencode_z_tb.sv ====
`timescale 1ns/1ps

module sigencode_z_tb;

    import mldsa_z_pkg::*;

    localparam int unsigned NUM_LANES      = 4;
    localparam int unsigned BEAT_W         = NUM_LANES * ZENC_W / 2;
    localparam logic [31:0] LFSR_SEED      = 32'h8bd1;
    localparam int unsigned RAND_GROUPS    = 40;
    localparam int unsigned BURST_GROUPS   = 6;
    // Boundary group, random groups, cleared group, partial plus recovery group, burst
    localparam int unsigned NUM_GROUPS     = 1 + RAND_GROUPS + 3 + BURST_GROUPS;
    localparam int unsigned TIMEOUT_CYCLES = 40 * NUM_GROUPS + 100;

    logic              clk;
    logic              reset_n;
    logic              zeroize;
    logic              coef_valid;
    coef_t             coef;
    logic              word_valid;
    logic [BEAT_W-1:0] word;
    logic              word_last;

    // Expected beats in output order, low half of each group first
    logic [BEAT_W-1:0]   exp_q [$];
    logic [BEAT_W-1:0]   exp_beat;
    logic [2*BEAT_W-1:0] partial_field;
    int unsigned         partial_cnt;
    int unsigned         value_errors = 0;
    int unsigned         cycle_cnt = 0;
    logic [31:0]         lfsr_state;
    string               test_name;
    int unsigned         bnd_z [4];
    zenc_t               bnd_enc [4];

    sigencode_z_top #(
        .NUM_LANES (NUM_LANES)
    ) dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .coef_valid_i (coef_valid),
        .coef_i       (coef),
        .word_valid_o (word_valid),
        .word_o       (word),
        .word_last_o  (word_last)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ----------------------------------------------------------
    // Reference model and random source
    // ----------------------------------------------------------

    // gamma1 - z taken modulo q, kept to the field width
    function automatic zenc_t encode_z(int unsigned z);
        int unsigned gamma1;
        gamma1 = 1 << GAMMA1_LOG;
        if (z <= gamma1) begin
            return zenc_t'(gamma1 - z);
        end
        return zenc_t'(gamma1 + MLDSA_Q - z);
    endfunction

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned take_bits(int unsigned n);
        int unsigned v;
        v = 0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | 32'(lfsr_state[0]);
        end
        return v;
    endfunction

    // Either a value in [0, gamma1] or a negative one held as q - m
    function automatic int unsigned random_z();
        if (take_bits(1) == 0) begin
            return take_bits(20) % ((1 << GAMMA1_LOG) + 1);
        end
        return MLDSA_Q - (1 + take_bits(19) % ((1 << GAMMA1_LOG) - 1));
    endfunction

    // Lane i lands at bit i*ZENC_W, a full group yields two beats
    task automatic model_accept(int unsigned z);
        partial_field[partial_cnt*ZENC_W +: ZENC_W] = encode_z(z);
        partial_cnt++;
        if (partial_cnt == NUM_LANES) begin
            exp_q.push_back(partial_field[BEAT_W-1:0]);
            exp_q.push_back(partial_field[2*BEAT_W-1:BEAT_W]);
            partial_cnt   = 0;
            partial_field = '0;
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus tasks, all entered 1 ns after a rising edge
    // ----------------------------------------------------------

    task automatic idle_cycles(int unsigned n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drive_coef(int unsigned z, int unsigned gap);
        coef_valid = 1'b1;
        coef       = coef_t'(z);
        model_accept(z);
        idle_cycles(1);
        coef_valid = 1'b0;
        idle_cycles(gap);
    endtask

    // The last lane always leaves one idle cycle before the next group
    task automatic send_random_group(bit with_gaps);
        int unsigned gap;
        for (int unsigned i = 0; i < NUM_LANES; i++) begin
            gap = with_gaps ? take_bits(2) % 3 : 0;
            if (i == NUM_LANES - 1 && gap == 0) begin
                gap = 1;
            end
            drive_coef(random_z(), gap);
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle_cycles(3);
    endtask

    task automatic pulse_zeroize();
        zeroize       = 1'b1;
        // Nothing that has not yet left the DUT survives zeroize
        exp_q.delete();
        partial_cnt   = 0;
        partial_field = '0;
        idle_cycles(1);
        zeroize = 1'b0;
    endtask

    // ----------------------------------------------------------
    // Output checking and run limit
    // ----------------------------------------------------------

    // Beats are compared mid-cycle where the registered outputs are settled
    always @(negedge clk) begin
        if (reset_n && word_valid) begin
            if (exp_q.size() == 0) begin
                value_errors++;
                $display("Beat arrived in %s while no complete group was pending", test_name);
            end else begin
                exp_beat = exp_q.pop_front();
                assert (word == exp_beat) else begin
                    value_errors++;
                    $display("Fail %s: expected %h, actual %h", test_name, exp_beat, word);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles with %0d beats still missing",
                     cycle_cnt, exp_q.size());
            $display("Errors: %0d value, %0d property", value_errors, dut0.props0.fail_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        coef_valid    = 1'b0;
        coef          = '0;
        lfsr_state    = LFSR_SEED;
        partial_cnt   = 0;
        partial_field = '0;
        test_name     = "reset";
        bnd_z   = '{0, 1 << GAMMA1_LOG, MLDSA_Q - 1, MLDSA_Q - (1 << GAMMA1_LOG) + 1};
        bnd_enc = '{20'h80000, 20'h00000, 20'h80001, 20'hfffff};
        idle_cycles(3);
        reset_n = 1'b1;
        idle_cycles(1);

        // Edges of the valid range, model checked against known results too
        test_name = "boundary";
        for (int i = 0; i < 4; i++) begin
            assert (encode_z(bnd_z[i]) == bnd_enc[i]) else begin
                value_errors++;
                $display("Fail %s: expected %h, actual %h", test_name, bnd_enc[i],
                         encode_z(bnd_z[i]));
            end
            drive_coef(bnd_z[i], (i == 3) ? 1 : 0);
        end
        wait_drained();

        test_name = "random";
        repeat (RAND_GROUPS) send_random_group(1'b1);
        wait_drained();

        // A full group is cleared in the cycle the packer would take it
        test_name = "zeroize";
        send_random_group(1'b0);
        pulse_zeroize();
        idle_cycles(6);

        // Half a group is thrown away and the lane counter starts over
        drive_coef(random_z(), 0);
        drive_coef(random_z(), 0);
        pulse_zeroize();
        idle_cycles(6);
        send_random_group(1'b0);
        wait_drained();

        test_name = "back_to_back";
        repeat (BURST_GROUPS) send_random_group(1'b0);
        wait_drained();

        $display("Errors: %0d value, %0d property", value_errors, dut0.props0.fail_count);
        if (value_errors == 0 && dut0.props0.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/mldsa_z_pkg.sv
hdl/z_coef_gather.sv
hdl/sigencode_z_unit.sv
hdl/z_beat_packer.sv
hdl/sigencode_z_top.sv
dv/sigencode_z_properties.sv
dv/sigencode_z_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sigencode_z_tb -f sources.f -o sim_z
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Assertion failures are counted by the testbench, so the run must not stop at the first
output=$(./obj_dir/sim_z +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
